// File: list.f
source/sw_axis_pkg.sv
source/sw_route_pkg.sv
source/route_cfg.sv
source/axis_route_mux.sv
source/axis_downsize.sv
source/axis_upsize.sv
source/axis_sync_fifo.sv
source/sw_40g_core.sv
verif/tb_sw_40g_core.sv

// File: source/axis_downsize.sv
`timescale 1ns/1ps
`default_nettype none

module axis_downsize
  import sw_axis_pkg::*;
(
  input  wire                      sys_clk,
  input  wire                      arst_n,
  input  wire  [wide_w-1:0]        in_tdata,
  input  wire  [wide_keep_w-1:0]   in_tkeep,
  input  wire                      in_tlast,
  input  wire                      in_tvalid,
  output logic                     in_tready,
  output logic [narrow_w-1:0]      out_tdata,
  output logic [narrow_keep_w-1:0] out_tkeep,
  output logic                     out_tlast,
  output logic                     out_tvalid,
  input  wire                      out_tready
);

  wide_beat_u                                   beat_q;
  logic [lanes_per_wide-1:0][narrow_keep_w-1:0] keep_q;
  logic                                         last_q;
  logic [lane_idx_w-1:0]                        idx_q;
  logic [lane_idx_w-1:0]                        top_idx_q;
  logic [lane_idx_w-1:0]                        top_idx;
  logic                                         busy_q;
  logic                                         busy_d;
  logic                                         in_fire;
  logic                                         out_fire;
  logic                                         last_word;

  assign in_fire   = in_tvalid && in_tready;
  assign out_fire  = out_tvalid && out_tready;
  assign last_word = (idx_q == top_idx_q);

  // highest narrow word with keep bytes, keep is contiguous
  always_comb
  begin
    top_idx = '0;
    for (int i = 0; i < lanes_per_wide; i++)
    begin
      if (|in_tkeep[i*narrow_keep_w +: narrow_keep_w])
        top_idx = lane_idx_w'(i);
    end
  end

  always_comb
  begin
    busy_d = busy_q;
    if (in_fire)
      busy_d = 1'b1;
    else if (out_fire && last_word)
      busy_d = 1'b0;
  end

  // --------------------
  // control
  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy_q    <= 1'b0;
      in_tready <= 1'b0;
      idx_q     <= '0;
    end
    else
    begin
      busy_q    <= busy_d;
      in_tready <= !busy_d;
      if (in_fire)
        idx_q <= '0;
      else if (out_fire)
        idx_q <= idx_q + 1'b1;
    end
  end

  // held wide beat
  always_ff @(posedge sys_clk)
  begin
    if (in_fire)
    begin
      beat_q.flat <= in_tdata;
      keep_q      <= in_tkeep;
      last_q      <= in_tlast;
      top_idx_q   <= top_idx;
    end
  end

  assign out_tvalid = busy_q;
  assign out_tdata  = beat_q.word[idx_q];
  assign out_tkeep  = keep_q[idx_q];
  assign out_tlast  = last_q && last_word;

endmodule

`default_nettype wire

// File: source/axis_route_mux.sv
`timescale 1ns/1ps
`default_nettype none

module axis_route_mux
  import sw_axis_pkg::*;
(
  input  wire                      sys_clk,
  input  wire                      arst_n,
  input  wire                      down_sel,
  // rx main, cut to 64 bits
  input  wire  [narrow_w-1:0]      main_tdata,
  input  wire  [narrow_keep_w-1:0] main_tkeep,
  input  wire                      main_tlast,
  input  wire                      main_tvalid,
  output logic                     main_tready,
  // rx back, cut to 64 bits
  input  wire  [narrow_w-1:0]      back_tdata,
  input  wire  [narrow_keep_w-1:0] back_tkeep,
  input  wire                      back_tlast,
  input  wire                      back_tvalid,
  output logic                     back_tready,
  // to 10g tx
  output logic [narrow_w-1:0]      out_tdata,
  output logic [narrow_keep_w-1:0] out_tkeep,
  output logic                     out_tlast,
  output logic                     out_tvalid,
  input  wire                      out_tready
);

  logic sel_q;
  logic in_frame;
  logic sel;
  logic out_fire;

  // selection frozen inside a frame
  assign sel      = in_frame ? sel_q : down_sel;
  assign out_fire = out_tvalid && out_tready;

  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sel_q    <= 1'b0;
      in_frame <= 1'b0;
    end
    else if (out_fire)
    begin
      in_frame <= !out_tlast;
      sel_q    <= sel;
    end
  end

  // --------------------
  // datapath
  assign out_tdata  = sel ? back_tdata : main_tdata;
  assign out_tkeep  = sel ? back_tkeep : main_tkeep;
  assign out_tlast  = sel ? back_tlast : main_tlast;
  assign out_tvalid = sel ? back_tvalid : main_tvalid;

  // unselected side is stalled
  assign main_tready = !sel && out_tready;
  assign back_tready = sel && out_tready;

endmodule

`default_nettype wire

// File: source/axis_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axis_sync_fifo
  import sw_axis_pkg::*;
(
  input  wire                      sys_clk,
  input  wire                      arst_n,
  input  wire  [narrow_w-1:0]      in_tdata,
  input  wire  [narrow_keep_w-1:0] in_tkeep,
  input  wire                      in_tlast,
  input  wire                      in_tvalid,
  output logic                     in_tready,
  output logic [narrow_w-1:0]      out_tdata,
  output logic [narrow_keep_w-1:0] out_tkeep,
  output logic                     out_tlast,
  output logic                     out_tvalid,
  input  wire                      out_tready
);

  // last, keep and data per entry
  logic [narrow_w+narrow_keep_w:0] mem [xmit_fifo_depth];
  logic [fifo_ptr_w-1:0]           wr_ptr;
  logic [fifo_ptr_w-1:0]           rd_ptr;
  logic [fifo_ptr_w:0]             count;
  logic [fifo_ptr_w:0]             count_d;
  logic                            in_fire;
  logic                            out_fire;

  assign in_fire  = in_tvalid && in_tready;
  assign out_fire = out_tvalid && out_tready;

  always_comb
  begin
    count_d = count;
    if (in_fire && !out_fire)
      count_d = count + 1'b1;
    else if (out_fire && !in_fire)
      count_d = count - 1'b1;
  end

  // --------------------
  // pointers and occupancy
  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_tready <= 1'b0;
    end
    else
    begin
      count     <= count_d;
      in_tready <= (count_d != (fifo_ptr_w + 1)'(xmit_fifo_depth));
      if (in_fire)
        wr_ptr <= wr_ptr + 1'b1;
      if (out_fire)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (in_fire)
      mem[wr_ptr] <= {in_tlast, in_tkeep, in_tdata};
  end

  // head entry shows as soon as it is written
  assign {out_tlast, out_tkeep, out_tdata} = mem[rd_ptr];
  assign out_tvalid = (count != '0);

endmodule

`default_nettype wire

// File: source/axis_upsize.sv
`timescale 1ns/1ps
`default_nettype none

module axis_upsize
  import sw_axis_pkg::*;
(
  input  wire                      sys_clk,
  input  wire                      arst_n,
  input  wire  [narrow_w-1:0]      in_tdata,
  input  wire  [narrow_keep_w-1:0] in_tkeep,
  input  wire                      in_tlast,
  input  wire                      in_tvalid,
  output logic                     in_tready,
  output logic [wide_w-1:0]        out_tdata,
  output logic [wide_keep_w-1:0]   out_tkeep,
  output logic                     out_tlast,
  output logic                     out_tvalid,
  input  wire                      out_tready
);

  wide_beat_u                                   beat_q;
  logic [lanes_per_wide-1:0][narrow_keep_w-1:0] keep_q;
  logic                                         last_q;
  logic [lane_idx_w-1:0]                        idx_q;
  logic                                         full_q;
  logic                                         full_d;
  logic                                         in_fire;
  logic                                         out_fire;
  logic                                         close;

  assign in_fire  = in_tvalid && in_tready;
  assign out_fire = out_tvalid && out_tready;

  // beat closes on its last slot or on a frame end
  assign close = in_fire && (in_tlast || idx_q == lane_idx_w'(lanes_per_wide - 1));

  always_comb
  begin
    full_d = full_q;
    if (close)
      full_d = 1'b1;
    else if (out_fire)
      full_d = 1'b0;
  end

  // --------------------
  // control
  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      full_q    <= 1'b0;
      in_tready <= 1'b0;
      idx_q     <= '0;
    end
    else
    begin
      full_q    <= full_d;
      in_tready <= !full_d;
      if (close)
        idx_q <= '0;
      else if (in_fire)
        idx_q <= idx_q + 1'b1;
    end
  end

  // slot fill
  // keep is cleared as a new beat starts so short beats carry zero keep above the data
  always_ff @(posedge sys_clk)
  begin
    if (in_fire)
    begin
      if (idx_q == '0)
        keep_q <= '0;
      keep_q[idx_q]      <= in_tkeep;
      beat_q.word[idx_q] <= in_tdata;
      last_q             <= in_tlast;
    end
  end

  assign out_tvalid = full_q;
  assign out_tdata  = beat_q.flat;
  assign out_tkeep  = keep_q;
  assign out_tlast  = last_q;

endmodule

`default_nettype wire

// File: source/route_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module route_cfg
  import sw_axis_pkg::*, sw_route_pkg::*;
(
  input  wire                    sys_clk,
  input  wire                    arst_n,
  input  wire  [route_w-1:0]     route_ctrl,
  // packed uplink from the upsizer
  input  wire  [wide_w-1:0]      up_tdata,
  input  wire  [wide_keep_w-1:0] up_tkeep,
  input  wire                    up_tlast,
  input  wire                    up_tvalid,
  output logic                   up_tready,
  // four-lane tx main
  output logic [wide_w-1:0]      main_tdata,
  output logic [wide_keep_w-1:0] main_tkeep,
  output logic                   main_tlast,
  output logic                   main_tvalid,
  input  wire                    main_tready,
  // four-lane tx back
  output logic [wide_w-1:0]      back_tdata,
  output logic [wide_keep_w-1:0] back_tkeep,
  output logic                   back_tlast,
  output logic                   back_tvalid,
  input  wire                    back_tready,
  // downlink mux output, only watched
  input  wire                    down_tvalid,
  input  wire                    down_tready,
  input  wire                    down_tlast,
  output logic                   down_sel
);

  logic [route_w-1:0] up_route;
  logic [route_w-1:0] down_route;
  logic               up_in_frame;
  logic               down_in_frame;
  logic               up_fire;
  logic               down_fire;

  assign up_fire   = up_tvalid && up_tready;
  assign down_fire = down_tvalid && down_tready;

  // --------------------
  // frame tracking per path
  // a route register only reloads while its path is idle
  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_route      <= route_park;
      down_route    <= route_park;
      up_in_frame   <= 1'b0;
      down_in_frame <= 1'b0;
    end
    else
    begin
      if (up_fire)
        up_in_frame <= !up_tlast;
      if (!up_in_frame && !up_fire)
        up_route <= route_ctrl;
      if (down_fire)
        down_in_frame <= !down_tlast;
      if (!down_in_frame && !down_fire)
        down_route <= route_ctrl;
    end
  end

  // --------------------
  // uplink steering
  assign main_tdata  = up_tdata;
  assign main_tkeep  = up_tkeep;
  assign main_tlast  = up_tlast;
  assign main_tvalid = up_tvalid && (up_route == route_main);

  assign back_tdata  = up_tdata;
  assign back_tkeep  = up_tkeep;
  assign back_tlast  = up_tlast;
  assign back_tvalid = up_tvalid && (up_route == route_back);

  // parked uplink holds the upsizer off
  always_comb
  begin
    case (up_route)
      route_main: up_tready = main_tready;
      route_back: up_tready = back_tready;
      default:    up_tready = 1'b0;
    endcase
  end

  // only route_back moves the downlink off rx main
  assign down_sel = (down_route == route_back);

endmodule

`default_nettype wire

// File: source/sw_40g_core.sv
`timescale 1ns/1ps
`default_nettype none

module sw_40g_core
  import sw_axis_pkg::*, sw_route_pkg::*;
(
  input  wire                          sys_clk,
  input  wire                          arst_n,
  input  wire [route_w-1:0]            route_ctrl,
  // single-lane aurora, data transmit
  input  wire [narrow_w-1:0]           lane1_rx_tdata,
  input  wire [narrow_keep_w-1:0]      lane1_rx_tkeep,
  input  wire                          lane1_rx_tlast,
  input  wire                          lane1_rx_tvalid,
  output wire                          lane1_rx_tready,
  output wire [narrow_w-1:0]           lane1_tx_tdata,
  output wire [narrow_keep_w-1:0]      lane1_tx_tkeep,
  output wire                          lane1_tx_tlast,
  output wire                          lane1_tx_tvalid,
  input  wire                          lane1_tx_tready,
  // four-lane aurora, [0] main and [1] back
  input  wire [1:0][wide_w-1:0]        lane4_rx_tdata,
  input  wire [1:0][wide_keep_w-1:0]   lane4_rx_tkeep,
  input  wire [1:0]                    lane4_rx_tlast,
  input  wire [1:0]                    lane4_rx_tvalid,
  output wire [1:0]                    lane4_rx_tready,
  output wire [1:0][wide_w-1:0]        lane4_tx_tdata,
  output wire [1:0][wide_keep_w-1:0]   lane4_tx_tkeep,
  output wire [1:0]                    lane4_tx_tlast,
  output wire [1:0]                    lane4_tx_tvalid,
  input  wire [1:0]                    lane4_tx_tready,
  // 10gbase-r, [0] is channel 0 (route) and [1] is channel 2 (data transmit)
  input  wire [1:0][narrow_w-1:0]      base10g_rx_tdata,
  input  wire [1:0][narrow_keep_w-1:0] base10g_rx_tkeep,
  input  wire [1:0]                    base10g_rx_tlast,
  input  wire [1:0]                    base10g_rx_tvalid,
  output wire [1:0]                    base10g_rx_tready,
  output wire [1:0][narrow_w-1:0]      base10g_tx_tdata,
  output wire [1:0][narrow_keep_w-1:0] base10g_tx_tkeep,
  output wire [1:0]                    base10g_tx_tlast,
  output wire [1:0]                    base10g_tx_tvalid,
  input  wire [1:0]                    base10g_tx_tready
);

  logic [1:0][narrow_w-1:0]      dn_tdata;
  logic [1:0][narrow_keep_w-1:0] dn_tkeep;
  logic [1:0]                    dn_tlast;
  logic [1:0]                    dn_tvalid;
  logic [1:0]                    dn_tready;
  logic                          down_sel;
  logic [wide_w-1:0]             up_tdata;
  logic [wide_keep_w-1:0]        up_tkeep;
  logic                          up_tlast;
  logic                          up_tvalid;
  logic                          up_tready;

  // --------------------
  // downlink, lane4 rx to 10g channel 0
  for (genvar i = 0; i < 2; i++)
  begin : g_down
    axis_downsize downsize_inst (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .in_tdata   (lane4_rx_tdata[i]),
      .in_tkeep   (lane4_rx_tkeep[i]),
      .in_tlast   (lane4_rx_tlast[i]),
      .in_tvalid  (lane4_rx_tvalid[i]),
      .in_tready  (lane4_rx_tready[i]),
      .out_tdata  (dn_tdata[i]),
      .out_tkeep  (dn_tkeep[i]),
      .out_tlast  (dn_tlast[i]),
      .out_tvalid (dn_tvalid[i]),
      .out_tready (dn_tready[i])
    );
  end

  axis_route_mux route_mux_inst (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .down_sel    (down_sel),
    .main_tdata  (dn_tdata[0]),
    .main_tkeep  (dn_tkeep[0]),
    .main_tlast  (dn_tlast[0]),
    .main_tvalid (dn_tvalid[0]),
    .main_tready (dn_tready[0]),
    .back_tdata  (dn_tdata[1]),
    .back_tkeep  (dn_tkeep[1]),
    .back_tlast  (dn_tlast[1]),
    .back_tvalid (dn_tvalid[1]),
    .back_tready (dn_tready[1]),
    .out_tdata   (base10g_tx_tdata[0]),
    .out_tkeep   (base10g_tx_tkeep[0]),
    .out_tlast   (base10g_tx_tlast[0]),
    .out_tvalid  (base10g_tx_tvalid[0]),
    .out_tready  (base10g_tx_tready[0])
  );

  // --------------------
  // uplink, 10g channel 0 to lane4 tx
  axis_upsize upsize_inst (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .in_tdata   (base10g_rx_tdata[0]),
    .in_tkeep   (base10g_rx_tkeep[0]),
    .in_tlast   (base10g_rx_tlast[0]),
    .in_tvalid  (base10g_rx_tvalid[0]),
    .in_tready  (base10g_rx_tready[0]),
    .out_tdata  (up_tdata),
    .out_tkeep  (up_tkeep),
    .out_tlast  (up_tlast),
    .out_tvalid (up_tvalid),
    .out_tready (up_tready)
  );

  route_cfg route_cfg_inst (
    .sys_clk     (sys_clk),
    .arst_n      (arst_n),
    .route_ctrl  (route_ctrl),
    .up_tdata    (up_tdata),
    .up_tkeep    (up_tkeep),
    .up_tlast    (up_tlast),
    .up_tvalid   (up_tvalid),
    .up_tready   (up_tready),
    .main_tdata  (lane4_tx_tdata[0]),
    .main_tkeep  (lane4_tx_tkeep[0]),
    .main_tlast  (lane4_tx_tlast[0]),
    .main_tvalid (lane4_tx_tvalid[0]),
    .main_tready (lane4_tx_tready[0]),
    .back_tdata  (lane4_tx_tdata[1]),
    .back_tkeep  (lane4_tx_tkeep[1]),
    .back_tlast  (lane4_tx_tlast[1]),
    .back_tvalid (lane4_tx_tvalid[1]),
    .back_tready (lane4_tx_tready[1]),
    .down_tvalid (base10g_tx_tvalid[0]),
    .down_tready (base10g_tx_tready[0]),
    .down_tlast  (base10g_tx_tlast[0]),
    .down_sel    (down_sel)
  );

  // --------------------
  // data transmit, lane1 to and from 10g channel 2
  axis_sync_fifo xmit_tx_inst (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .in_tdata   (lane1_rx_tdata),
    .in_tkeep   (lane1_rx_tkeep),
    .in_tlast   (lane1_rx_tlast),
    .in_tvalid  (lane1_rx_tvalid),
    .in_tready  (lane1_rx_tready),
    .out_tdata  (base10g_tx_tdata[1]),
    .out_tkeep  (base10g_tx_tkeep[1]),
    .out_tlast  (base10g_tx_tlast[1]),
    .out_tvalid (base10g_tx_tvalid[1]),
    .out_tready (base10g_tx_tready[1])
  );

  axis_sync_fifo xmit_rx_inst (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .in_tdata   (base10g_rx_tdata[1]),
    .in_tkeep   (base10g_rx_tkeep[1]),
    .in_tlast   (base10g_rx_tlast[1]),
    .in_tvalid  (base10g_rx_tvalid[1]),
    .in_tready  (base10g_rx_tready[1]),
    .out_tdata  (lane1_tx_tdata),
    .out_tkeep  (lane1_tx_tkeep),
    .out_tlast  (lane1_tx_tlast),
    .out_tvalid (lane1_tx_tvalid),
    .out_tready (lane1_tx_tready)
  );

endmodule

`default_nettype wire

// File: source/sw_axis_pkg.sv
`default_nettype none

package sw_axis_pkg;

  // --------------------
  // stream widths

  // single-lane aurora and 10gbase-r
  localparam int narrow_w      = 64;
  localparam int narrow_keep_w = 8;

  // four-lane aurora
  localparam int wide_w         = 256;
  localparam int wide_keep_w    = 32;
  localparam int lanes_per_wide = 4;
  localparam int lane_idx_w     = $clog2(lanes_per_wide);

  // --------------------
  // data-transmit buffer
  localparam int xmit_fifo_depth = 16;
  localparam int fifo_ptr_w      = $clog2(xmit_fifo_depth);

  // one wide beat, flat or as narrow words with word 0 in the low bits
  typedef union packed
  {
    logic [wide_w-1:0]                       flat;
    logic [lanes_per_wide-1:0][narrow_w-1:0] word;
  } wide_beat_u;

endpackage

`default_nettype wire

// File: source/sw_route_pkg.sv
`default_nettype none

package sw_route_pkg;

  localparam int route_w = 2;

  // uplink parked, downlink on rx main
  // code 3 behaves the same way
  localparam logic [route_w-1:0] route_park = 2'd0;

  // uplink to four-lane tx main
  localparam logic [route_w-1:0] route_main = 2'd1;

  // uplink to tx back, downlink from rx back
  localparam logic [route_w-1:0] route_back = 2'd2;

endpackage

`default_nettype wire

// File: verif/tb_sw_40g_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sw_40g_core
  import sw_axis_pkg::*, sw_route_pkg::*;
();

  localparam int clk_period     = 20;
  localparam int n_frames       = 6;
  localparam int max_narrow_len = 12;
  localparam int max_wide_len   = 4;
  // every beat of every test, each given 20 cycles, plus a margin
  localparam int max_beats = 2 * n_frames * max_narrow_len
                           + 3 * n_frames * max_wide_len * lanes_per_wide
                           + 3 * n_frames * max_narrow_len + 64;
  localparam longint watchdog_ns = longint'(max_beats * 20 + 1000) * clk_period;

  logic                          sys_clk;
  logic                          arst_n;
  logic [route_w-1:0]            route_ctrl;
  logic [narrow_w-1:0]           lane1_rx_tdata;
  logic [narrow_keep_w-1:0]      lane1_rx_tkeep;
  logic                          lane1_rx_tlast;
  logic                          lane1_rx_tvalid;
  logic                          lane1_rx_tready;
  logic [narrow_w-1:0]           lane1_tx_tdata;
  logic [narrow_keep_w-1:0]      lane1_tx_tkeep;
  logic                          lane1_tx_tlast;
  logic                          lane1_tx_tvalid;
  logic                          lane1_tx_tready;
  logic [1:0][wide_w-1:0]        lane4_rx_tdata;
  logic [1:0][wide_keep_w-1:0]   lane4_rx_tkeep;
  logic [1:0]                    lane4_rx_tlast;
  logic [1:0]                    lane4_rx_tvalid;
  logic [1:0]                    lane4_rx_tready;
  logic [1:0][wide_w-1:0]        lane4_tx_tdata;
  logic [1:0][wide_keep_w-1:0]   lane4_tx_tkeep;
  logic [1:0]                    lane4_tx_tlast;
  logic [1:0]                    lane4_tx_tvalid;
  logic [1:0]                    lane4_tx_tready;
  logic [1:0][narrow_w-1:0]      base10g_rx_tdata;
  logic [1:0][narrow_keep_w-1:0] base10g_rx_tkeep;
  logic [1:0]                    base10g_rx_tlast;
  logic [1:0]                    base10g_rx_tvalid;
  logic [1:0]                    base10g_rx_tready;
  logic [1:0][narrow_w-1:0]      base10g_tx_tdata;
  logic [1:0][narrow_keep_w-1:0] base10g_tx_tkeep;
  logic [1:0]                    base10g_tx_tlast;
  logic [1:0]                    base10g_tx_tvalid;
  logic [1:0]                    base10g_tx_tready;

  // beats are kept as {last, keep[31:0], data[255:0]}
  // outputs 0 10g ch2, 1 lane1 tx, 2 10g ch0, 3 lane4 tx main, 4 lane4 tx back
  logic [288:0] exp_q [5][$];
  logic [288:0] pend_q [$];
  logic [288:0] prev_beat [5];
  logic         prev_stall [5];
  string        cur_test;
  int           errors;
  int           tests_run;
  int           tests_failed;
  logic         rand_ready;
  logic         watch_back;
  logic         back_held;
  logic         back_done;

  sw_40g_core dut0 (.*);

  initial
  begin
    sys_clk = 1'b0;
    forever #(clk_period / 2) sys_clk = ~sys_clk;
  end

  initial
  begin
    #(watchdog_ns);
    $display("timeout: the DUT stopped moving beats before the tests completed");
    $display("Test FAILED");
    $finish;
  end

  // --------------------
  // helpers
  function automatic logic [288:0] pack_narrow(logic [63:0] d, logic [7:0] k, logic l);
    return {l, 24'h0, k, 192'h0, d};
  endfunction

  function automatic logic keep_ok(logic [31:0] k);
    return (k != 0) && ((k & (k + 32'd1)) == 0);
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  task automatic fail_value(string what, logic [288:0] exp, logic [288:0] act);
    errors++;
    $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
  endtask

  task automatic fail_text(string text);
    errors++;
    $display("FAIL %s %s", cur_test, text);
  endtask

  task automatic step();
    @(posedge sys_clk);
    #2;
  endtask

  function automatic logic [288:0] out_beat(int k);
    case (k)
      0: return pack_narrow(base10g_tx_tdata[1], base10g_tx_tkeep[1], base10g_tx_tlast[1]);
      1: return pack_narrow(lane1_tx_tdata, lane1_tx_tkeep, lane1_tx_tlast);
      2: return pack_narrow(base10g_tx_tdata[0], base10g_tx_tkeep[0], base10g_tx_tlast[0]);
      3: return {lane4_tx_tlast[0], lane4_tx_tkeep[0], lane4_tx_tdata[0]};
      default: return {lane4_tx_tlast[1], lane4_tx_tkeep[1], lane4_tx_tdata[1]};
    endcase
  endfunction

  function automatic logic out_valid(int k);
    case (k)
      0: return base10g_tx_tvalid[1];
      1: return lane1_tx_tvalid;
      2: return base10g_tx_tvalid[0];
      3: return lane4_tx_tvalid[0];
      default: return lane4_tx_tvalid[1];
    endcase
  endfunction

  function automatic logic out_ready(int k);
    case (k)
      0: return base10g_tx_tready[1];
      1: return lane1_tx_tready;
      2: return base10g_tx_tready[0];
      3: return lane4_tx_tready[0];
      default: return lane4_tx_tready[1];
    endcase
  endfunction

  task automatic check_beat(int k, logic [288:0] exp, logic [288:0] act);
    logic [255:0] mask;
    for (int b = 0; b < 32; b++)
      mask[b*8 +: 8] = {8{exp[256+b]}};
    assert ((exp[288:256] == act[288:256]) && (((exp[255:0] ^ act[255:0]) & mask) == 0))
    else fail_value($sformatf("output %0d beat", k), exp, act);
  endtask

  // --------------------
  // output monitors, sampled mid-cycle where everything is stable
  always @(negedge sys_clk)
  begin
    logic [288:0] beat;
    if (arst_n)
    begin
      for (int k = 0; k < 5; k++)
      begin
        beat = out_beat(k);
        if (prev_stall[k])
        begin
          assert (out_valid(k) && beat === prev_beat[k])
          else fail_text($sformatf("output %0d changed while stalled", k));
        end
        if (out_valid(k))
        begin
          assert (keep_ok(beat[287:256]))
          else fail_text($sformatf("output %0d keep %h is not contiguous", k, beat[287:256]));
          assert (exp_q[k].size() != 0)
          else fail_text($sformatf("output %0d presented a beat that was never sent", k));
          if (out_ready(k) && exp_q[k].size() != 0)
            check_beat(k, exp_q[k].pop_front(), beat);
        end
        prev_stall[k] = out_valid(k) && !out_ready(k);
        prev_beat[k]  = beat;
      end
      if (watch_back)
      begin
        assert (!(back_held && lane4_rx_tready[1]))
        else fail_text("unselected lane4 rx back took a beat while it held one");
        if (lane4_rx_tvalid[1] && lane4_rx_tready[1])
          back_held = 1'b1;
      end
    end
  end

  // random back-pressure on every sink
  always @(posedge sys_clk)
  begin
    #2;
    if (rand_ready)
    begin
      lane1_tx_tready   <= ($urandom % 4) != 0;
      lane4_tx_tready   <= {($urandom % 4) != 0, ($urandom % 4) != 0};
      base10g_tx_tready <= {($urandom % 4) != 0, ($urandom % 4) != 0};
    end
  end

  // --------------------
  // sources
  // src 0 lane1 rx, 1 10g rx ch2, 2 10g rx ch0
  task automatic drive_narrow(int src, logic [63:0] d, logic [7:0] k, logic l);
    logic acc;
    case (src)
      0: {lane1_rx_tdata, lane1_rx_tkeep, lane1_rx_tlast, lane1_rx_tvalid} = {d, k, l, 1'b1};
      1: {base10g_rx_tdata[1], base10g_rx_tkeep[1], base10g_rx_tlast[1],
          base10g_rx_tvalid[1]} = {d, k, l, 1'b1};
      default: {base10g_rx_tdata[0], base10g_rx_tkeep[0], base10g_rx_tlast[0],
                base10g_rx_tvalid[0]} = {d, k, l, 1'b1};
    endcase
    do
    begin
      @(negedge sys_clk);
      acc = (src == 0) ? lane1_rx_tready : base10g_rx_tready[src == 1 ? 1 : 0];
      step();
    end
    while (!acc);
    case (src)
      0: lane1_rx_tvalid = 1'b0;
      1: base10g_rx_tvalid[1] = 1'b0;
      default: base10g_rx_tvalid[0] = 1'b0;
    endcase
  endtask

  // dst picks the lane4 tx channel for uplink frames, -1 expects nothing
  task automatic send_narrow(int src, int len, int dst);
    logic [63:0]  d;
    logic [7:0]   k;
    logic [255:0] wd;
    logic [31:0]  wk;
    int           slot;
    logic         l;
    wd   = '0;
    wk   = '0;
    slot = 0;
    for (int i = 0; i < len; i++)
    begin
      d = {$urandom, $urandom};
      l = (i == len - 1);
      k = l ? 8'((9'h1 << rand_range(1, 8)) - 1) : 8'hff;
      if (src < 2)
        exp_q[src].push_back(pack_narrow(d, k, l));
      else if (dst >= 0)
      begin
        wd[slot*64 +: 64] = d;
        wk[slot*8 +: 8]   = k;
        if (slot == lanes_per_wide - 1 || l)
        begin
          exp_q[3 + dst].push_back({l, wk, wd});
          wk   = '0;
          slot = 0;
        end
        else
          slot++;
      end
      drive_narrow(src, d, k, l);
    end
  endtask

  task automatic send_wide(int ch, int len, logic to_pend);
    logic [255:0] d;
    logic [31:0]  k;
    int           nbytes;
    logic         l;
    for (int i = 0; i < len; i++)
    begin
      for (int w = 0; w < 8; w++)
        d[w*32 +: 32] = $urandom;
      l      = (i == len - 1);
      nbytes = l ? rand_range(1, 32) : 32;
      k      = 32'((33'h1 << nbytes) - 1);
      for (int w = 0; w < (nbytes + 7) / 8; w++)
      begin
        if (to_pend)
          pend_q.push_back(pack_narrow(d[w*64 +: 64], k[w*8 +: 8], l && w == (nbytes - 1) / 8));
        else
          exp_q[2].push_back(pack_narrow(d[w*64 +: 64], k[w*8 +: 8], l && w == (nbytes - 1) / 8));
      end
      {lane4_rx_tdata[ch], lane4_rx_tkeep[ch], lane4_rx_tlast[ch]} = {d, k, l};
      lane4_rx_tvalid[ch] = 1'b1;
      do
      begin
        @(negedge sys_clk);
        l = lane4_rx_tready[ch];
        step();
      end
      while (!l);
      lane4_rx_tvalid[ch] = 1'b0;
    end
  endtask

  // parked beats join the 10g ch0 scoreboard once their route is open
  task automatic release_pending();
    while (pend_q.size() != 0)
      exp_q[2].push_back(pend_q.pop_front());
  endtask

  task automatic wait_drain();
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size()
           + exp_q[3].size() + exp_q[4].size() != 0)
      @(negedge sys_clk);
    step();
  endtask

  task automatic wait_fire(int k);
    do
      @(negedge sys_clk);
    while (!(out_valid(k) && out_ready(k)));
    step();
  endtask

  task automatic check_idle();
    assert (lane1_rx_tready == 0 && lane1_tx_tvalid == 0 && lane4_rx_tready == 0
            && lane4_tx_tvalid == 0 && base10g_rx_tready == 0 && base10g_tx_tvalid == 0)
    else fail_text("a tvalid or tready output was high around reset");
  endtask

  task automatic finish_test(int err_start);
    tests_run++;
    if (errors == err_start)
      $display("%s: pass", cur_test);
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", cur_test, errors - err_start);
    end
  endtask

  // --------------------
  // test sequence
  initial
  begin
    int err_start;
    void'($urandom(32'h593a9d05));
    {arst_n, route_ctrl, rand_ready, watch_back, back_held, back_done} = '0;
    {lane1_rx_tdata, lane1_rx_tkeep, lane1_rx_tlast, lane1_rx_tvalid} = '0;
    {lane4_rx_tdata, lane4_rx_tkeep, lane4_rx_tlast, lane4_rx_tvalid} = '0;
    {base10g_rx_tdata, base10g_rx_tkeep, base10g_rx_tlast, base10g_rx_tvalid} = '0;
    {lane1_tx_tready, lane4_tx_tready, base10g_tx_tready} = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int k = 0; k < 5; k++)
      prev_stall[k] = 1'b0;

    cur_test  = "reset";
    err_start = errors;
    repeat (5)
    begin
      @(negedge sys_clk);
      check_idle();
      @(posedge sys_clk);
    end
    #2;
    arst_n = 1'b1;
    @(negedge sys_clk);
    check_idle();
    step();
    finish_test(err_start);
    rand_ready = 1'b1;

    cur_test  = "transmit";
    err_start = errors;
    fork
      for (int f = 0; f < n_frames; f++)
        send_narrow(0, rand_range(1, max_narrow_len), -1);
      for (int f = 0; f < n_frames; f++)
        send_narrow(1, rand_range(1, max_narrow_len), -1);
    join
    wait_drain();
    finish_test(err_start);

    // rx back is offered while parked and may only hold its first beat
    cur_test  = "downlink";
    err_start = errors;
    route_ctrl = route_park;
    watch_back = 1'b1;
    fork
      begin
        send_wide(1, 3, 1'b1);
        back_done = 1'b1;
      end
    join_none
    for (int f = 0; f < n_frames; f++)
      send_wide(0, rand_range(1, max_wide_len), 1'b0);
    wait_drain();
    watch_back = 1'b0;
    release_pending();
    route_ctrl = route_back;
    wait (back_done);
    release_pending();
    step();
    for (int f = 0; f < n_frames; f++)
      send_wide(1, rand_range(1, max_wide_len), 1'b0);
    wait_drain();
    finish_test(err_start);

    cur_test  = "uplink";
    err_start = errors;
    route_ctrl = route_main;
    step();
    for (int f = 0; f < n_frames; f++)
      send_narrow(2, rand_range(1, max_narrow_len), 0);
    wait_drain();
    route_ctrl = route_back;
    step();
    for (int f = 0; f < n_frames; f++)
      send_narrow(2, rand_range(1, max_narrow_len), 1);
    wait_drain();
    finish_test(err_start);

    cur_test  = "route change";
    err_start = errors;
    fork
      send_wide(1, 4, 1'b0);
      begin
        wait_fire(2);
        route_ctrl = route_park;
      end
    join
    send_wide(0, 2, 1'b0);
    wait_drain();
    route_ctrl = route_main;
    step();
    fork
      send_narrow(2, 12, 0);
      begin
        wait_fire(3);
        route_ctrl = route_back;
      end
    join
    send_narrow(2, 6, 1);
    wait_drain();
    finish_test(err_start);

    // parked uplink fills the upsizer once and then stalls
    cur_test  = "uplink park";
    err_start = errors;
    route_ctrl = route_park;
    step();
    fork
      send_narrow(2, 10, -1);
    join_none
    while (base10g_rx_tready[0] || !base10g_rx_tvalid[0])
      @(negedge sys_clk);
    repeat (30)
    begin
      @(negedge sys_clk);
      assert (!base10g_rx_tready[0] && lane4_tx_tvalid == 2'b00)
      else fail_text("parked uplink moved data");
    end
    finish_test(err_start);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
